//--- dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  // address and data widths
  localparam int ADDR_W = 32;
  localparam int XLEN   = 64;

  // line geometry: 64 lines of 64 bytes
  localparam int OFFSET_W = 6;
  localparam int INDEX_W  = 6;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  localparam int BEATS_PER_LINE = 8; // 64-bit beats per line fill

  // everything with all of these bits set is uncached
  localparam logic [ADDR_W-1:0] MMIO_BASE = 32'hA000_0000;

  // one-hot access size, same encoding as the cpu size field
  localparam logic [3:0] SIZE_B = 4'b0001;
  localparam logic [3:0] SIZE_H = 4'b0010;
  localparam logic [3:0] SIZE_W = 4'b0100;
  localparam logic [3:0] SIZE_D = 4'b1000;

  // controller states
  typedef enum logic [3:0] {
    RESET         = 4'd0,
    IDLE          = 4'd1,
    READ_HIT      = 4'd2,
    READ_MISS     = 4'd3,
    WRITE_HIT     = 4'd4,
    WRITE_MISS    = 4'd5,
    UNCACHE_READ  = 4'd6,
    UNCACHE_WRITE = 4'd7
  } dcache_state_e;

endpackage

`default_nettype wire

//--- dcache_tag.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag #(
  parameter int INDEX_W = 6,
  parameter int TAG_W   = 20
) (
  input  wire               clk,
  input  wire               rst,
  input  wire [INDEX_W-1:0] index_i,
  input  wire [TAG_W-1:0]   tag_i,
  input  wire               write_valid_i, // line fill finished
  output logic              hit_o
);

  localparam int LINES = 2 ** INDEX_W;

  logic [TAG_W-1:0] tag_mem [LINES];
  logic [LINES-1:0] valid_q;

  // one valid bit per line
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (write_valid_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write_valid_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  // combinational lookup on the live address
  assign hit_o = valid_q[index_i] && (tag_mem[index_i] == tag_i);

  // fill-done comes only from the last burst beat
  a_tag_write_single : assert property (
    @(posedge clk) disable iff (rst)
    write_valid_i |=> !write_valid_i
  ) else $error("CHECK FAILED: tag write held two cycles at %0t", $time);

endmodule

`default_nettype wire

//--- dcache_data.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data #(
  parameter int INDEX_W  = 6,
  parameter int OFFSET_W = 6
) (
  input  wire                                  clk,
  input  wire [INDEX_W+OFFSET_W-4:0]           word_addr_i, // {index, dword}
  input  wire                                  wen_i,
  input  wire [dcache_pkg::XLEN/8-1:0]         wbe_i,
  input  wire [dcache_pkg::XLEN-1:0]           wdata_i,
  output logic [dcache_pkg::XLEN-1:0]          rdata_o
);

  localparam int LANES   = dcache_pkg::XLEN / 8;
  localparam int WORD_AW = INDEX_W + OFFSET_W - $clog2(LANES);
  localparam int DEPTH   = 2 ** WORD_AW; // 512 dwords for 4 KB

  logic [dcache_pkg::XLEN-1:0] mem [DEPTH];

  // byte lanes are written independently
  always_ff @(posedge clk) begin
    if (wen_i) begin
      for (int b = 0; b < LANES; b++) begin
        if (wbe_i[b]) begin
          mem[word_addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // synchronous read every cycle, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rdata_o <= mem[word_addr_i];
  end

endmodule

`default_nettype wire

//--- dcache_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_load_align (
  input  wire [dcache_pkg::XLEN-1:0]  word_i,
  input  wire [2:0]                   offset_i, // byte within the dword
  input  wire [3:0]                   size_i,   // one-hot
  output logic [dcache_pkg::XLEN-1:0] data_o
);

  localparam int XLEN = dcache_pkg::XLEN;

  logic [XLEN-1:0] shifted;

  // addressed byte moves down to bit 0
  assign shifted = word_i >> {offset_i, 3'b000};

  always_comb begin
    case (size_i)
      dcache_pkg::SIZE_B: begin
        data_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
      end
      dcache_pkg::SIZE_H: begin
        data_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
      end
      dcache_pkg::SIZE_W: begin
        data_o = {{(XLEN-32){1'b0}}, shifted[31:0]};
      end
      default: begin
        data_o = shifted; // full dword
      end
    endcase
  end

endmodule

`default_nettype wire

//--- dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int INDEX_W  = dcache_pkg::INDEX_W,
  parameter int OFFSET_W = dcache_pkg::OFFSET_W,
  parameter int TAG_W    = dcache_pkg::TAG_W
) (
  input  wire                                 clk,
  input  wire                                 rst,
  // cpu side
  input  wire  [dcache_pkg::ADDR_W-1:0]       mem_addr_i,
  input  wire  [dcache_pkg::XLEN/8-1:0]       mem_mask_i,
  input  wire  [3:0]                          mem_size_i,
  input  wire                                 mem_addr_valid_i,
  input  wire                                 mem_write_valid_i,
  input  wire  [dcache_pkg::XLEN-1:0]         mem_wdata_i,
  output logic [dcache_pkg::XLEN-1:0]         mem_rdata_o,
  output logic                                mem_data_ready_o,
  // memory read port
  output logic [dcache_pkg::ADDR_W-1:0]       ram_raddr_o,
  output logic                                ram_raddr_valid_o,
  output logic [3:0]                          ram_rsize_o,
  output logic [7:0]                          ram_rlen_o,
  input  wire                                 ram_rdata_ready_i,
  input  wire  [dcache_pkg::XLEN-1:0]         ram_rdata_i,
  // memory write port
  output logic [dcache_pkg::ADDR_W-1:0]       ram_waddr_o,
  output logic                                ram_waddr_valid_o,
  output logic [dcache_pkg::XLEN/8-1:0]       ram_wmask_o,
  output logic [3:0]                          ram_wsize_o,
  output logic [dcache_pkg::XLEN-1:0]         ram_wdata_o,
  input  wire                                 ram_wdata_ready_i
);

  localparam int LANES  = dcache_pkg::XLEN / 8;
  localparam int LANE_W = $clog2(LANES);
  localparam int BEAT_W = OFFSET_W - LANE_W; // dword number within a line
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(dcache_pkg::BEATS_PER_LINE - 1);

  // live address fields
  logic [TAG_W-1:0]    addr_tag;
  logic [INDEX_W-1:0]  addr_idx;
  logic [OFFSET_W-1:0] addr_off;
  logic                uncache;

  assign {addr_tag, addr_idx, addr_off} = mem_addr_i;
  assign uncache = (mem_addr_i & dcache_pkg::MMIO_BASE) == dcache_pkg::MMIO_BASE;

  dcache_pkg::dcache_state_e state_q;

  logic [INDEX_W-1:0]  idx_q;
  logic [OFFSET_W-1:0] off_q;
  logic [3:0]          size_q;
  logic                uncache_q;  // selects the uncached read register
  logic [BEAT_W-1:0]   beat_q;
  logic [dcache_pkg::XLEN-1:0] unc_rdata_q;

  logic hit;
  logic take_req;
  logic rd_hs;
  logic wr_hs;
  logic fill_done;

  // no new sample in the ready cycle, the cpu still holds the old request there
  assign take_req  = mem_addr_valid_i && !mem_data_ready_o;
  assign rd_hs     = ram_raddr_valid_o && ram_rdata_ready_i;
  assign wr_hs     = ram_waddr_valid_o && ram_wdata_ready_i;
  assign fill_done = (state_q == dcache_pkg::READ_MISS) && rd_hs && (beat_q == LAST_BEAT);

  // controller
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q           <= dcache_pkg::RESET;
      mem_data_ready_o  <= 1'b0;
      ram_raddr_valid_o <= 1'b0;
      ram_waddr_valid_o <= 1'b0;
      beat_q            <= '0;
    end else begin
      mem_data_ready_o <= 1'b0; // single-cycle pulse by default
      case (state_q)
        dcache_pkg::RESET: begin
          state_q <= dcache_pkg::IDLE;
        end
        dcache_pkg::IDLE: begin
          if (take_req) begin
            if (mem_write_valid_i) begin
              ram_waddr_valid_o <= 1'b1;  // write-through on every path
              if (uncache) begin
                state_q <= dcache_pkg::UNCACHE_WRITE;
              end else if (hit) begin
                state_q <= dcache_pkg::WRITE_HIT;
              end else begin
                state_q <= dcache_pkg::WRITE_MISS; // no allocate
              end
            end else if (uncache) begin
              state_q           <= dcache_pkg::UNCACHE_READ;
              ram_raddr_valid_o <= 1'b1;
            end else if (hit) begin
              state_q <= dcache_pkg::READ_HIT; // wait for the array read
            end else begin
              state_q           <= dcache_pkg::READ_MISS;
              ram_raddr_valid_o <= 1'b1;
              beat_q            <= '0;
            end
          end
        end
        dcache_pkg::READ_HIT: begin
          mem_data_ready_o <= 1'b1;
          state_q          <= dcache_pkg::IDLE;
        end
        dcache_pkg::READ_MISS: begin
          if (fill_done) begin
            ram_raddr_valid_o <= 1'b0;
            state_q           <= dcache_pkg::IDLE; // held request hits next
          end else if (rd_hs) begin
            beat_q <= beat_q + 1'b1;
          end
        end
        dcache_pkg::UNCACHE_READ: begin
          if (rd_hs) begin
            ram_raddr_valid_o <= 1'b0;
            mem_data_ready_o  <= 1'b1;
            state_q           <= dcache_pkg::IDLE;
          end
        end
        dcache_pkg::WRITE_HIT, dcache_pkg::WRITE_MISS, dcache_pkg::UNCACHE_WRITE: begin
          if (wr_hs) begin
            ram_waddr_valid_o <= 1'b0;
            mem_data_ready_o  <= 1'b1;
            state_q           <= dcache_pkg::IDLE;
          end
        end
        default: begin
          state_q <= dcache_pkg::IDLE;
        end
      endcase
    end
  end

  // request fields, captured once per sample and held under back-pressure
  always_ff @(posedge clk) begin
    if (state_q == dcache_pkg::IDLE && take_req) begin
      idx_q     <= addr_idx;
      off_q     <= addr_off;
      size_q    <= mem_size_i;
      uncache_q <= uncache;
      ram_waddr_o <= mem_addr_i;
      ram_wmask_o <= mem_mask_i;
      ram_wsize_o <= mem_size_i;
      ram_wdata_o <= mem_wdata_i;
      if (uncache) begin
        ram_raddr_o <= mem_addr_i;
        ram_rsize_o <= mem_size_i;
        ram_rlen_o  <= 8'd0;                 // single beat
      end else begin
        ram_raddr_o <= {addr_tag, addr_idx, {OFFSET_W{1'b0}}}; // line base
        ram_rsize_o <= dcache_pkg::SIZE_D;
        ram_rlen_o  <= 8'(dcache_pkg::BEATS_PER_LINE - 1);
      end
    end
    if (state_q == dcache_pkg::UNCACHE_READ && rd_hs) begin
      unc_rdata_q <= ram_rdata_i; // dword holding the addressed bytes
    end
  end

  // data array port
  logic [INDEX_W+BEAT_W-1:0]   word_addr;
  logic                        data_wen;
  logic [LANES-1:0]            data_wbe;
  logic [dcache_pkg::XLEN-1:0] data_wdata;
  logic [dcache_pkg::XLEN-1:0] data_rdata;
  logic                        filling;

  assign filling = state_q == dcache_pkg::READ_MISS;

  always_comb begin
    if (state_q == dcache_pkg::IDLE) begin
      word_addr = {addr_idx, addr_off[OFFSET_W-1:LANE_W]}; // lookup read
    end else if (filling) begin
      word_addr = {idx_q, beat_q};
    end else begin
      word_addr = {idx_q, off_q[OFFSET_W-1:LANE_W]};
    end
  end

  assign data_wen   = (filling && rd_hs) || (state_q == dcache_pkg::WRITE_HIT && wr_hs);
  assign data_wbe   = filling ? {LANES{1'b1}} : ram_wmask_o;
  assign data_wdata = filling ? ram_rdata_i : ram_wdata_o;

  dcache_tag #(
    .INDEX_W (INDEX_W),
    .TAG_W   (TAG_W)
  ) u_dcache_tag (
    .clk           (clk),
    .rst           (rst),
    .index_i       (addr_idx),
    .tag_i         (addr_tag),
    .write_valid_i (fill_done),
    .hit_o         (hit)
  );

  dcache_data #(
    .INDEX_W  (INDEX_W),
    .OFFSET_W (OFFSET_W)
  ) u_dcache_data (
    .clk         (clk),
    .word_addr_i (word_addr),
    .wen_i       (data_wen),
    .wbe_i       (data_wbe),
    .wdata_i     (data_wdata),
    .rdata_o     (data_rdata)
  );

  dcache_load_align u_dcache_load_align (
    .word_i   (uncache_q ? unc_rdata_q : data_rdata),
    .offset_i (off_q[LANE_W-1:0]),
    .size_i   (size_q),
    .data_o   (mem_rdata_o)
  );

  a_one_port_busy : assert property (
    @(posedge clk) disable iff (rst)
    !(ram_raddr_valid_o && ram_waddr_valid_o)
  ) else $error("CHECK FAILED: read and write valid together at %0t", $time);

  a_raddr_stable : assert property (
    @(posedge clk) disable iff (rst)
    (ram_raddr_valid_o && !ram_rdata_ready_i) |=> $stable(ram_raddr_o)
  ) else $error("CHECK FAILED: read address moved under back-pressure at %0t", $time);

  a_ready_pulse : assert property (
    @(posedge clk) disable iff (rst)
    mem_data_ready_o |=> !mem_data_ready_o
  ) else $error("CHECK FAILED: cpu ready high two cycles at %0t", $time);

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  wire         clk,
  input  wire         rst,
  input  wire  [31:0] raddr_i,
  input  wire         raddr_valid_i,
  output logic        rdata_ready_o,
  output logic [63:0] rdata_o,
  input  wire  [31:0] waddr_i,
  input  wire         waddr_valid_i,
  input  wire  [7:0]  wmask_i,
  input  wire  [63:0] wdata_i,
  output logic        wdata_ready_o
);

  logic [63:0] words [logic [28:0]]; // only written dwords are stored
  int seed = 77165;
  int delay;
  int beat;
  logic rd_hs;
  logic wr_hs;

  // same address pattern as the testbench image
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return (a[7:0] + 8'h3c) ^ a[15:8] ^ {a[22:16], a[23]} ^ a[31:24];
  endfunction

  function automatic logic [63:0] read_word(input logic [28:0] w);
    logic [63:0] v;
    if (words.exists(w)) begin
      return words[w];
    end
    for (int b = 0; b < 8; b++) begin
      v[8*b +: 8] = fill_byte({w, 3'(b)});
    end
    return v;
  endfunction

  initial begin
    logic [63:0] v;
    rdata_ready_o = 1'b0;
    wdata_ready_o = 1'b0;
    rdata_o       = '0;
    delay         = 0;
    beat          = 0;
    forever begin
      @(posedge clk);
      rd_hs = raddr_valid_i && rdata_ready_o;
      wr_hs = waddr_valid_i && wdata_ready_o;
      if (wr_hs && !rst) begin
        v = read_word(waddr_i[31:3]);
        for (int b = 0; b < 8; b++) begin
          if (wmask_i[b]) v[8*b +: 8] = wdata_i[8*b +: 8];
        end
        words[waddr_i[31:3]] = v;
      end
      #1;
      if (rd_hs) beat++;
      if (rd_hs || wr_hs) delay = {$random(seed)} % 4; // next beat waits 0..3 cycles
      if (!raddr_valid_i || rst) beat = 0;
      rdata_ready_o = 1'b0;
      wdata_ready_o = 1'b0;
      if (raddr_valid_i || waddr_valid_i) begin
        if (delay == 0) begin
          rdata_ready_o = raddr_valid_i;
          wdata_ready_o = waddr_valid_i;
        end else begin
          delay--;
        end
      end
      rdata_o = read_word(raddr_i[31:3] + 29'(beat)); // ascending beats from base
    end
  end

endmodule

`default_nettype wire

//--- tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

  logic        clk;
  logic        rst;
  logic [31:0] mem_addr_i;
  logic [7:0]  mem_mask_i;
  logic [3:0]  mem_size_i;
  logic        mem_addr_valid_i;
  logic        mem_write_valid_i;
  logic [63:0] mem_wdata_i;
  logic [63:0] mem_rdata_o;
  logic        mem_data_ready_o;
  logic [31:0] ram_raddr_o;
  logic        ram_raddr_valid_o;
  logic [3:0]  ram_rsize_o;
  logic [7:0]  ram_rlen_o;
  logic        ram_rdata_ready_i;
  logic [63:0] ram_rdata_i;
  logic [31:0] ram_waddr_o;
  logic        ram_waddr_valid_o;
  logic [7:0]  ram_wmask_o;
  logic [3:0]  ram_wsize_o;
  logic [63:0] ram_wdata_o;
  logic        ram_wdata_ready_i;

  logic [7:0] img [logic [31:0]]; // reference image of written bytes
  int seed = 77165;
  int err_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;
  int test_err_base = 0;
  int rd_req_cnt = 0;
  int wr_req_cnt = 0;
  logic       rd_prev = 1'b0;
  logic       wr_prev = 1'b0;
  logic [7:0] last_rlen;
  logic [3:0]  last_rsize;
  logic [31:0] last_waddr;
  logic [7:0]  last_wmask;
  logic [3:0]  last_wsize;
  logic [63:0] last_wdata;

  dcache_top uut (.*);

  tb_mem_model u_mem (
    .clk (clk), .rst (rst),
    .raddr_i (ram_raddr_o), .raddr_valid_i (ram_raddr_valid_o),
    .rdata_ready_o (ram_rdata_ready_i), .rdata_o (ram_rdata_i),
    .waddr_i (ram_waddr_o), .waddr_valid_i (ram_waddr_valid_o),
    .wmask_i (ram_wmask_o), .wdata_i (ram_wdata_o),
    .wdata_ready_o (ram_wdata_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // counts memory requests by their rising valid
  always @(posedge clk) begin
    if (!rst) begin
      if (ram_raddr_valid_o && !rd_prev) begin
        rd_req_cnt++;
        last_rlen  = ram_rlen_o;
        last_rsize = ram_rsize_o;
      end
      if (ram_waddr_valid_o && !wr_prev) begin
        wr_req_cnt++;
        last_waddr = ram_waddr_o;
        last_wmask = ram_wmask_o;
        last_wsize = ram_wsize_o;
        last_wdata = ram_wdata_o;
      end
    end
    rd_prev = ram_raddr_valid_o;
    wr_prev = ram_waddr_valid_o;
  end

  // fills are line-aligned 8-beat bursts and uncached reads single beats
  a_read_shape : assert property (
    @(posedge clk) disable iff (rst)
    $rose(ram_raddr_valid_o) |=>
      (((ram_raddr_o & 32'hA000_0000) == 32'hA000_0000) ? (ram_rlen_o == 8'd0)
        : (ram_rlen_o == 8'd7 && ram_raddr_o[5:0] == 6'd0))
  ) else begin
    err_cnt++;
    $display("CHECK FAILED at %0t: bad burst shape addr %h len %0d", $time,
             ram_raddr_o, ram_rlen_o);
  end

  a_ready_has_req : assert property (
    @(posedge clk) disable iff (rst)
    mem_data_ready_o |-> mem_addr_valid_i
  ) else begin
    err_cnt++;
    $display("CHECK FAILED at %0t: cpu ready without a request", $time);
  end

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return (a[7:0] + 8'h3c) ^ a[15:8] ^ {a[22:16], a[23]} ^ a[31:24];
  endfunction

  function automatic logic [7:0] img_byte(input logic [31:0] a);
    return img.exists(a) ? img[a] : fill_byte(a);
  endfunction

  function automatic int size_bytes(input logic [3:0] size);
    case (size)
      4'b0001: return 1;
      4'b0010: return 2;
      4'b0100: return 4;
      default: return 8;
    endcase
  endfunction

  // right-aligned, zero-extended load from the image
  function automatic logic [63:0] expect_load(input logic [31:0] addr, input logic [3:0] size);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < size_bytes(size); i++) begin
      v[8*i +: 8] = img_byte(addr + 32'(i));
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic cpu_read(input logic [31:0] addr, input logic [3:0] size,
                          output logic [63:0] data, output int waited);
    int n;
    n = 0;
    mem_addr_i        = addr;
    mem_size_i        = size;
    mem_write_valid_i = 1'b0;
    mem_addr_valid_i  = 1'b1;
    @(negedge clk);
    while (!mem_data_ready_o) begin
      n++;
      @(negedge clk);
    end
    data   = mem_rdata_o;
    waited = n;
    @(posedge clk);
    #1 mem_addr_valid_i = 1'b0;
  endtask

  task automatic cpu_write(input logic [31:0] addr, input logic [3:0] size,
                           input logic [7:0] mask, input logic [63:0] data);
    mem_addr_i        = addr;
    mem_size_i        = size;
    mem_mask_i        = mask;
    mem_wdata_i       = data;
    mem_write_valid_i = 1'b1;
    mem_addr_valid_i  = 1'b1;
    @(negedge clk);
    while (!mem_data_ready_o) @(negedge clk);
    @(posedge clk);
    #1;
    mem_addr_valid_i  = 1'b0;
    mem_write_valid_i = 1'b0;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) img[{addr[31:3], 3'(b)}] = data[8*b +: 8];
    end
  endtask

  task automatic read_and_check(input logic [31:0] addr, input logic [3:0] size);
    logic [63:0] d;
    int w;
    cpu_read(addr, size, d, w);
    check_value($sformatf("load %h size %b", addr, size), d, expect_load(addr, size));
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s finished with %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  initial begin
    #20000; // 20 us covers every test at worst-case memory delays
    $display("watchdog expired, the run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [63:0] d;
    logic [31:0] a;
    logic [3:0]  sz;
    logic [63:0] wd;
    int w;
    int n;
    int r0;
    rst = 1'b1;
    mem_addr_i = '0;
    mem_mask_i = '0;
    mem_size_i = 4'b1000;
    mem_addr_valid_i = 1'b0;
    mem_write_valid_i = 1'b0;
    mem_wdata_i = '0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    repeat (2) @(posedge clk);
    #1;

    // line fill and a hit in the same line
    r0 = rd_req_cnt;
    read_and_check(32'h0000_1000, 4'b1000);
    check_value("fill requests", 64'(rd_req_cnt - r0), 64'd1);
    check_value("fill length", 64'(last_rlen), 64'd7);
    check_value("fill beat size", 64'(last_rsize), 64'(4'b1000));
    r0 = rd_req_cnt;
    cpu_read(32'h0000_1028, 4'b0100, d, w);
    check_value("hit data", d, expect_load(32'h0000_1028, 4'b0100));
    check_value("hit latency", 64'(w), 64'd2);
    check_value("hit requests", 64'(rd_req_cnt - r0), 64'd0);
    end_test("line fill");

    // every size at each aligned offset
    for (int off = 0; off < 16; off++) begin
      read_and_check(32'h0000_2040 + 32'(off), 4'b0001);
      if (off % 2 == 0) read_and_check(32'h0000_2040 + 32'(off), 4'b0010);
      if (off % 4 == 0) read_and_check(32'h0000_2040 + 32'(off), 4'b0100);
      if (off % 8 == 0) read_and_check(32'h0000_2040 + 32'(off), 4'b1000);
    end
    end_test("aligned loads");

    // write hit goes through to memory and into the line
    n = wr_req_cnt;
    cpu_write(32'h0000_1010, 4'b0100, 8'b0011_1100, 64'h1122_3344_5566_7788);
    check_value("write hit beats", 64'(wr_req_cnt - n), 64'd1);
    check_value("write hit address", 64'(last_waddr), 64'h1010);
    check_value("write hit mask", 64'(last_wmask), 64'h3c);
    check_value("write hit size", 64'(last_wsize), 64'(4'b0100));
    check_value("write hit data", last_wdata, 64'h1122_3344_5566_7788);
    r0 = rd_req_cnt;
    read_and_check(32'h0000_1010, 4'b1000);
    check_value("merged read requests", 64'(rd_req_cnt - r0), 64'd0);
    end_test("write hit");

    // write miss leaves the cache alone
    r0 = rd_req_cnt;
    n = wr_req_cnt;
    cpu_write(32'h0000_3088, 4'b1000, 8'hff, 64'hdead_beef_0bad_f00d);
    check_value("write miss beats", 64'(wr_req_cnt - n), 64'd1);
    check_value("write miss address", 64'(last_waddr), 64'h3088);
    check_value("write miss read requests", 64'(rd_req_cnt - r0), 64'd0);
    read_and_check(32'h0000_3088, 4'b1000);
    check_value("refill after write miss", 64'(rd_req_cnt - r0), 64'd1);
    end_test("write miss");

    // uncached region
    r0 = rd_req_cnt;
    read_and_check(32'hA000_0014, 4'b0100);
    check_value("uncached length", 64'(last_rlen), 64'd0);
    check_value("uncached read size", 64'(last_rsize), 64'(4'b0100));
    read_and_check(32'hA000_0014, 4'b0100);
    check_value("uncached requests", 64'(rd_req_cnt - r0), 64'd2);
    cpu_write(32'hA000_0020, 4'b0100, 8'h0f, 64'h0000_0000_cafe_babe);
    check_value("uncached write address", 64'(last_waddr), 64'hA000_0020);
    check_value("uncached write size", 64'(last_wsize), 64'(4'b0100));
    read_and_check(32'hA000_0020, 4'b1000);
    end_test("uncached");

    // conflict eviction and mixed random traffic
    read_and_check(32'h0000_1000, 4'b1000);
    r0 = rd_req_cnt;
    read_and_check(32'h0000_5000, 4'b1000); // same index with a new tag
    read_and_check(32'h0000_1008, 4'b1000);
    check_value("conflict refills", 64'(rd_req_cnt - r0), 64'd2);
    for (int i = 0; i < 16; i++) begin
      sz = 4'b0001 << ({$random(seed)} % 4);
      a  = {18'd0, 14'($random(seed))} & ~32'(size_bytes(sz) - 1);
      wd = {$random(seed), $random(seed)};
      if ($random(seed) & 1) begin
        cpu_write(a, sz, 8'((1 << size_bytes(sz)) - 1) << a[2:0], wd);
      end else begin
        read_and_check(a, sz);
      end
    end
    end_test("back-pressure and conflict");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dcache.f
dcache_pkg.sv
dcache_tag.sv
dcache_data.sv
dcache_load_align.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_dcache
FILELIST  ?= dcache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o sim_bin -f $(FILELIST)
	./$(OBJ_DIR)/sim_bin | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
